//--- all.f
+incdir+hw
hw/spmv_cmd_pkg.sv
hw/spmv_mem_pkg.sv
hw/spmv_ctrl.sv
hw/spmv_prefetch.sv
hw/spmv_elem_fetch.sv
hw/spmv_mem_port.sv
hw/spmv_mac.sv
hw/spmv_result_buf.sv
hw/spmv_top.sv
dv/spmv_assert.sv
dv/spmv_tb.sv

//--- dv/spmv_assert.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_assert
    import spmv_mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_req_val,
    input  logic                       mem_req_rdy,
    input  logic [`SPMV_TRANSID_W-1:0] mem_req_transid,
    input  paddr_t                     mem_req_addr,
    input  logic                       mem_resp_val,
    input  logic                       resp_val,
    input  logic                       resp_rdy,
    input  mem_word_t                  resp_data
);

    int out_cnt;  // Requests still waiting for a response

    always_ff @(posedge clk) begin
        if (!rst_n) out_cnt <= 0;
        else out_cnt <= out_cnt + int'(mem_req_val && mem_req_rdy) - int'(mem_resp_val);
    end

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_addr)
                                        && $stable(mem_req_transid))
        else $error("memory request changed while stalled");

    resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_val && !resp_rdy |=> resp_val && $stable(resp_data))
        else $error("core response changed while stalled");

    out_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= `SPMV_MAX_OUT)
        else $error("too many memory requests in flight");

endmodule

bind spmv_top spmv_assert i_assert (.*);

//--- dv/spmv_tb.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_tb
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
;

    localparam int   MEM_WORDS = 4096;
    localparam int   VEC_BASE  = 2048;  // Vector region, matrix sits below it
    localparam int   MAX_RL    = 8;     // Longest random row

    logic                       clk, rst_n, cmd_val, busy, resp_val, resp_rdy;
    logic [5:0]                 cmd_opcode;
    mem_word_t                  cmd_config_data, resp_data, mem_resp_data;
    logic                       mem_req_rdy, mem_req_val, mem_resp_val;
    logic [`SPMV_TRANSID_W-1:0] mem_req_transid, mem_resp_transid;
    paddr_t                     mem_req_addr;

    mem_word_t mem [MEM_WORDS];      // Backing store
    logic [`SPMV_TRANSID_W-1:0] tid_q[$];
    paddr_t    addr_q[$];            // In-order pending requests
    mem_word_t exp_q[$];             // Expected responses
    int        rl [`SPMV_MAX_DIM];   // Row lengths of the current matrix
    elem_t     vals[$], cols[$];
    elem_t     vec [`SPMV_MAX_DIM];
    int        nr, nnz, vec_len, req_seen, limit_cycles;
    int        nr_t [4];

    spmv_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;  // 8 ns
    end

    //////////////////////////////
    // Reporting and checks
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("result word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("control level mismatch");
        end
    endtask

    // y[r] from the matrix as built here, 32-bit wrap
    function automatic elem_t spmv_ref(input int r);
        int    start;
        elem_t acc;
        start = 0;
        acc   = '0;
        for (int i = 0; i < r; i++) start += rl[i];
        for (int k = start; k < start + rl[r]; k++) acc += vals[k] * vec[cols[k]];
        return acc;
    endfunction

    //////////////////////////////
    // Memory model
    //////////////////////////////

    always @(posedge clk) begin
        if (rst_n && mem_req_val && mem_req_rdy) begin
            req_seen++;
            tid_q.push_back(mem_req_transid);
            addr_q.push_back(mem_req_addr);
        end
    end

    always @(negedge clk) begin
        mem_req_rdy  <= ($urandom % 3) != 0;  // Random back-pressure
        resp_rdy     <= ($urandom % 4) != 0;
        mem_resp_val <= 1'b0;
        if (addr_q.size() > 0 && ($urandom % 3) != 0) begin  // Random latency, in order
            mem_resp_val     <= 1'b1;
            mem_resp_transid <= tid_q.pop_front();
            mem_resp_data    <= mem[addr_q.pop_front() % MEM_WORDS];
        end
    end

    // Compare each core response handshake
    always @(posedge clk) begin
        if (rst_n && resp_val && resp_rdy) begin
            if (exp_q.size() == 0) abort_run("more responses than rows");
            else check_word("resp_data", resp_data, exp_q.pop_front());
        end
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic send_cmd(input spmv_opcode_e op, input mem_word_t data);
        @(negedge clk);
        while (busy) @(negedge clk);  // Accepted only when idle
        cmd_val         = 1'b1;
        cmd_opcode      = {4'b0, op};
        cmd_config_data = data;
        @(negedge clk);
        cmd_val = 1'b0;
    endtask

    task automatic build_matrix(input int rows, input bit many_zero);
        nr  = rows;
        nnz = 0;
        vals.delete();
        cols.delete();
        vec_len = 1 + ($urandom % `SPMV_MAX_DIM);
        for (int r = 0; r < nr; r++) begin
            rl[r] = $urandom % (MAX_RL + 1);
            if (many_zero && (r == 0 || ($urandom % 2) == 0)) rl[r] = 0;
        end
        if (many_zero && nr > 1) rl[nr-1] = 1 + ($urandom % MAX_RL);  // Keeps nnz above 0
        else if (rl[0] == 0) rl[0] = 1;
        for (int r = 0; r < nr; r++) nnz += rl[r];
        for (int k = 0; k < nnz; k++) begin
            vals.push_back($urandom);
            cols.push_back(elem_t'($urandom % vec_len));
            mem[k]       = mem_word_t'(vals[k]);
            mem[nnz + k] = mem_word_t'(cols[k]);
        end
        for (int r = 0; r < nr; r++) mem[2 * nnz + r] = mem_word_t'(rl[r]);
        for (int j = 0; j < vec_len; j++) begin
            vec[j]            = $urandom;
            mem[VEC_BASE + j] = mem_word_t'(vec[j]);
        end
    endtask

    // Loads the matrix and waits for compute to end
    task automatic run_matrix();
        send_cmd(INIT_SPMV, 64'd0);
        send_cmd(LD_SPM_DATA, (mem_word_t'(nr) << 16) | mem_word_t'(nnz));
        send_cmd(LD_VEC_DATA, (mem_word_t'(vec_len) << 40) | mem_word_t'(VEC_BASE));
        check_bit("busy", busy, 1'b1);
        while (busy) @(negedge clk);
    endtask

    task automatic read_results();
        for (int r = 0; r < nr; r++) exp_q.push_back(mem_word_t'(spmv_ref(r)));
        send_cmd(GET_RESULT, 64'd0);
        check_bit("resp_val", resp_val, 1'b1);  // Rises right after acceptance
        while (exp_q.size() > 0) @(negedge clk);
        repeat (20) begin  // No extra words, back to idle
            @(negedge clk);
            check_bit("resp_val", resp_val, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'hb178));
        req_seen        = 0;
        limit_cycles    = 0;
        rst_n           = 1'b0;
        cmd_val         = 1'b0;
        cmd_opcode      = '0;
        cmd_config_data = '0;
        resp_rdy        = 1'b0;
        mem_req_rdy     = 1'b0;
        mem_resp_val    = 1'b0;
        mem_resp_transid = '0;
        mem_resp_data   = '0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = {32'h5a5a_0000 ^ i, 32'(i) * 32'h9e37_79b1};
        for (int t = 0; t < 4; t++) nr_t[t] = 1 + ($urandom % `SPMV_MAX_DIM);
        nr_t[0] = `SPMV_MAX_DIM;  // One full-size matrix
        limit_cycles = 4000;
        for (int t = 0; t < 4; t++) limit_cycles += 16 * (nr_t[t] * (2 * MAX_RL + 1) + 64);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("resp_val", resp_val, 1'b0);
        check_bit("mem_req_val", mem_req_val, 1'b0);

        // Out-of-state commands in IDLE
        send_cmd(LD_VEC_DATA, (mem_word_t'(8) << 40) | mem_word_t'(VEC_BASE));
        send_cmd(GET_RESULT, 64'd0);
        repeat (10) begin
            @(negedge clk);
            check_bit("busy", busy, 1'b0);
            check_bit("resp_val", resp_val, 1'b0);
            check_bit("mem_req_val", mem_req_val, 1'b0);
        end
        if (req_seen != 0) abort_run("memory request issued from IDLE");

        build_matrix(nr_t[0], 1'b0);
        run_matrix();
        read_results();

        build_matrix(nr_t[1], 1'b1);  // Many empty rows
        run_matrix();
        read_results();

        build_matrix(nr_t[2], 1'b0);  // Left in SPMV_FINISHED, then replaced
        run_matrix();
        build_matrix(nr_t[3], 1'b1);
        run_matrix();
        read_results();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- hw/spmv_cmd_pkg.sv
`include "spmv_settings.svh"

package spmv_cmd_pkg;

    // Low two bits of cmd_opcode
    typedef enum logic [1:0] {
        INIT_SPMV   = 2'd0,  // Matrix base pointer
        LD_SPM_DATA = 2'd1,  // nnz and row count
        LD_VEC_DATA = 2'd2,  // Vector pointer and length
        GET_RESULT  = 2'd3   // Stream y back
    } spmv_opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        SPMV_INIT,      // Collecting the two load commands
        VEC_PREFETCH,   // Vector and row lengths into local stores
        SPMV_COMPUTE,   // Element stream through the MAC
        SPMV_FINISHED   // Results held, waiting for GET_RESULT
    } spmv_state_e;

    typedef logic [`SPMV_DIM_W:0]   dim_t;   // One extra bit so 64 fits
    typedef logic [`SPMV_NNZ_W-1:0] nnz_t;
    typedef logic [`SPMV_DATA_W-1:0] elem_t;

endpackage

//--- hw/spmv_ctrl.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_ctrl
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_val,
    input  logic [5:0] cmd_opcode,
    input  mem_word_t cmd_config_data,
    output logic      busy,
    input  logic      prefetch_done,
    input  dim_t      rows_done,
    input  logic      readout_done,
    input  logic      readout_active,
    output logic      phase_prefetch,
    output logic      phase_compute,
    output logic      phase_init,
    output logic      readout_start,
    output paddr_t    val_ptr,
    output paddr_t    col_ptr,
    output paddr_t    rowlen_ptr,
    output paddr_t    vec_ptr,
    output dim_t      vec_len,
    output nnz_t      spm_nnz,
    output dim_t      spm_nr
);

    localparam int NR_LSB = 16;  // Row count field in LD_SPM_DATA

    spmv_opcode_e op;
    spmv_state_e  state;
    logic [1:0]   load_cnt;  // Loads seen since INIT_SPMV
    logic         cmd_hsk, start_init, ld_spm, ld_vec;
    nnz_t         cmd_nnz;

    //////////////////////////////
    // Command decode
    //////////////////////////////

    assign op         = spmv_opcode_e'(cmd_opcode[1:0]);
    assign cmd_hsk    = cmd_val && !busy;
    assign cmd_nnz    = cmd_config_data[`SPMV_NNZ_W-1:0];
    assign start_init = cmd_hsk && op == INIT_SPMV
                        && (state == IDLE || state == SPMV_FINISHED);
    assign ld_spm     = cmd_hsk && state == SPMV_INIT && op == LD_SPM_DATA;
    assign ld_vec     = cmd_hsk && state == SPMV_INIT && op == LD_VEC_DATA;

    assign phase_init     = state == SPMV_INIT;  // Clears the datapath counters
    assign phase_prefetch = state == VEC_PREFETCH;
    assign phase_compute  = state == SPMV_COMPUTE;
    assign readout_start  = cmd_hsk && state == SPMV_FINISHED && op == GET_RESULT;
    assign busy           = phase_prefetch || phase_compute || readout_active;

    //////////////////////////////
    // Phase FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            load_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_init) begin
                        state    <= SPMV_INIT;
                        load_cnt <= '0;
                    end
                end
                SPMV_INIT: begin
                    if (ld_spm || ld_vec) begin
                        load_cnt <= load_cnt + 2'd1;
                        if (load_cnt == 2'd1) state <= VEC_PREFETCH;  // Second load
                    end
                end
                VEC_PREFETCH: if (prefetch_done) state <= SPMV_COMPUTE;
                SPMV_COMPUTE: if (rows_done == spm_nr) state <= SPMV_FINISHED;
                SPMV_FINISHED: begin
                    if (start_init) begin  // New matrix replaces the old one
                        state    <= SPMV_INIT;
                        load_cnt <= '0;
                    end else if (readout_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Pointers and sizes
    always_ff @(posedge clk) begin
        if (start_init) val_ptr <= cmd_config_data[`SPMV_PADDR_W-1:0];
        if (ld_spm) begin
            spm_nnz    <= cmd_nnz;
            spm_nr     <= cmd_config_data[NR_LSB +: `SPMV_DIM_W+1];
            col_ptr    <= val_ptr + paddr_t'(cmd_nnz);          // Right after values
            rowlen_ptr <= val_ptr + (paddr_t'(cmd_nnz) << 1);   // After column indices
        end
        if (ld_vec) begin
            vec_ptr <= cmd_config_data[`SPMV_PADDR_W-1:0];
            vec_len <= cmd_config_data[`SPMV_PADDR_W +: `SPMV_DIM_W+1];
        end
    end

endmodule

//--- hw/spmv_elem_fetch.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_elem_fetch
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      phase_init,
    input  logic      phase_compute,
    input  paddr_t    val_ptr,
    input  paddr_t    col_ptr,
    input  nnz_t      spm_nnz,
    output logic      req_val,
    input  logic      req_rdy,
    output paddr_t    req_addr,
    output mem_kind_e req_kind,
    input  logic      resp_seen
);

    localparam int               OUT_W   = $clog2(`SPMV_MAX_OUT + 1);
    localparam logic [OUT_W-1:0] MAX_OUT = OUT_W'(`SPMV_MAX_OUT);

    nnz_t             k;        // Element index
    logic             sel_col;  // Value sent, column next
    logic [OUT_W-1:0] out_cnt;
    logic             req_hsk, resp_dec;

    assign req_val  = phase_compute && k < spm_nnz && out_cnt < MAX_OUT;
    assign req_kind = sel_col ? KIND_COL : KIND_VAL;
    assign req_addr = (sel_col ? col_ptr : val_ptr) + paddr_t'(k);
    assign req_hsk  = req_val && req_rdy;
    assign resp_dec = phase_compute && resp_seen;  // Only element responses in this phase

    always_ff @(posedge clk) begin
        if (!rst_n || phase_init) begin
            k       <= '0;
            sel_col <= 1'b0;
            out_cnt <= '0;
        end else begin
            if (req_hsk) begin
                sel_col <= !sel_col;
                if (sel_col) k <= k + nnz_t'(1);  // Pair done
            end
            out_cnt <= out_cnt + OUT_W'(req_hsk) - OUT_W'(resp_dec);
        end
    end

endmodule

//--- hw/spmv_mac.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_mac
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   phase_init,
    input  logic                   phase_compute,
    input  logic                   val_resp_val,
    input  logic                   col_resp_val,
    input  mem_word_t              resp_data,
    output logic [`SPMV_DIM_W-1:0] vec_rd_idx,
    input  elem_t                  vec_rd_data,
    output logic [`SPMV_DIM_W-1:0] row_rd_idx,
    input  dim_t                   row_rd_len,
    input  dim_t                   spm_nr,
    output logic                   row_wr_val,
    output logic [`SPMV_DIM_W-1:0] row_wr_idx,
    output elem_t                  row_wr_data,
    output dim_t                   rows_done
);

    elem_t val_q;                      // Value awaiting its column
    elem_t prod_mem [`SPMV_MAX_DIM];   // Products wait here while empty rows close
    dim_t  wr_ptr, rd_ptr;
    dim_t  row, cnt;                   // Current row and elements summed so far
    elem_t acc;
    logic  row_open, pop;

    assign vec_rd_idx = resp_data[`SPMV_DIM_W-1:0];  // Column index straight from memory
    assign row_rd_idx = row[`SPMV_DIM_W-1:0];

    // Row closes once full, zero-length rows close at once with 0
    assign row_open    = phase_compute && row < spm_nr;
    assign row_wr_val  = row_open && cnt == row_rd_len;
    assign row_wr_idx  = row[`SPMV_DIM_W-1:0];
    assign row_wr_data = acc;
    assign pop         = row_open && cnt != row_rd_len && wr_ptr != rd_ptr;
    assign rows_done   = row;

    always_ff @(posedge clk) begin
        if (val_resp_val) val_q <= resp_data[`SPMV_DATA_W-1:0];
        if (col_resp_val) prod_mem[wr_ptr[`SPMV_DIM_W-1:0]] <= val_q * vec_rd_data;  // Wraps
    end

    always_ff @(posedge clk) begin
        if (!rst_n || phase_init) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            row    <= '0;
            cnt    <= '0;
            acc    <= '0;
        end else begin
            if (col_resp_val) wr_ptr <= wr_ptr + dim_t'(1);
            if (row_wr_val) begin
                row <= row + dim_t'(1);
                cnt <= '0;
                acc <= '0;
            end else if (pop) begin
                acc    <= acc + prod_mem[rd_ptr[`SPMV_DIM_W-1:0]];
                cnt    <= cnt + dim_t'(1);
                rd_ptr <= rd_ptr + dim_t'(1);
            end
        end
    end

endmodule

//--- hw/spmv_mem_pkg.sv
`include "spmv_settings.svh"

package spmv_mem_pkg;

    typedef logic [`SPMV_PADDR_W-1:0] paddr_t;
    typedef logic [`SPMV_MEM_W-1:0]   mem_word_t;

    // Upper two transid bits, responses come back in order
    typedef enum logic [1:0] {
        KIND_VEC,
        KIND_ROWLEN,
        KIND_VAL,
        KIND_COL
    } mem_kind_e;

endpackage

//--- hw/spmv_mem_port.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_mem_port
    import spmv_mem_pkg::*;
(
    input  logic                       phase_prefetch,
    input  logic                       phase_compute,
    input  logic                       pf_req_val,
    output logic                       pf_req_rdy,
    input  paddr_t                     pf_req_addr,
    input  mem_kind_e                  pf_req_kind,
    input  logic                       ef_req_val,
    output logic                       ef_req_rdy,
    input  paddr_t                     ef_req_addr,
    input  mem_kind_e                  ef_req_kind,
    input  logic                       mem_req_rdy,
    output logic                       mem_req_val,
    output logic [`SPMV_TRANSID_W-1:0] mem_req_transid,
    output paddr_t                     mem_req_addr,
    input  logic                       mem_resp_val,
    input  logic [`SPMV_TRANSID_W-1:0] mem_resp_transid,
    input  mem_word_t                  mem_resp_data,
    output logic                       vec_resp_val,
    output logic                       rowlen_resp_val,
    output logic                       val_resp_val,
    output logic                       col_resp_val,
    output mem_word_t                  resp_data
);

    mem_kind_e req_kind, resp_kind;

    // Request side granted by phase
    always_comb begin
        mem_req_val  = 1'b0;
        pf_req_rdy   = 1'b0;
        ef_req_rdy   = 1'b0;
        mem_req_addr = pf_req_addr;
        req_kind     = pf_req_kind;
        if (phase_prefetch) begin
            mem_req_val = pf_req_val;
            pf_req_rdy  = mem_req_rdy;
        end else if (phase_compute) begin
            mem_req_val  = ef_req_val;
            ef_req_rdy   = mem_req_rdy;
            mem_req_addr = ef_req_addr;
            req_kind     = ef_req_kind;
        end
    end

    assign mem_req_transid = {req_kind, mem_req_addr[`SPMV_TRANSID_W-3:0]};  // Low bits tag only

    // Response routing by kind
    assign resp_kind       = mem_kind_e'(mem_resp_transid[`SPMV_TRANSID_W-1 -: 2]);
    assign vec_resp_val    = mem_resp_val && resp_kind == KIND_VEC;
    assign rowlen_resp_val = mem_resp_val && resp_kind == KIND_ROWLEN;
    assign val_resp_val    = mem_resp_val && resp_kind == KIND_VAL;
    assign col_resp_val    = mem_resp_val && resp_kind == KIND_COL;
    assign resp_data       = mem_resp_data;

endmodule

//--- hw/spmv_prefetch.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_prefetch
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   phase_init,
    input  logic                   phase_prefetch,
    input  paddr_t                 vec_ptr,
    input  dim_t                   vec_len,
    input  paddr_t                 rowlen_ptr,
    input  dim_t                   spm_nr,
    output logic                   req_val,
    input  logic                   req_rdy,
    output paddr_t                 req_addr,
    output mem_kind_e              req_kind,
    input  logic                   vec_resp_val,
    input  logic                   rowlen_resp_val,
    input  mem_word_t              resp_data,
    output logic                   prefetch_done,
    input  logic [`SPMV_DIM_W-1:0] vec_rd_idx,
    output elem_t                  vec_rd_data,
    input  logic [`SPMV_DIM_W-1:0] row_rd_idx,
    output dim_t                   row_rd_len
);

    localparam int               OUT_W   = $clog2(`SPMV_MAX_OUT + 1);
    localparam logic [OUT_W-1:0] MAX_OUT = OUT_W'(`SPMV_MAX_OUT);

    dim_t             vec_issued, row_issued;  // Requests sent
    dim_t             vec_got, row_got;        // Responses stored
    logic [OUT_W-1:0] out_cnt;
    logic             vec_left, row_left, req_hsk, resp_any;
    elem_t            vec_mem [`SPMV_MAX_DIM];
    dim_t             row_mem [`SPMV_MAX_DIM];

    // Whole vector first, then the row lengths
    assign vec_left = vec_issued < vec_len;
    assign row_left = row_issued < spm_nr;
    assign req_val  = phase_prefetch && (vec_left || row_left) && out_cnt < MAX_OUT;
    assign req_kind = vec_left ? KIND_VEC : KIND_ROWLEN;
    assign req_addr = vec_left ? vec_ptr + paddr_t'(vec_issued)
                               : rowlen_ptr + paddr_t'(row_issued);
    assign req_hsk  = req_val && req_rdy;
    assign resp_any = vec_resp_val || rowlen_resp_val;

    assign prefetch_done = phase_prefetch && vec_got == vec_len && row_got == spm_nr;

    // Read ports for the MAC
    assign vec_rd_data = vec_mem[vec_rd_idx];
    assign row_rd_len  = row_mem[row_rd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n || phase_init) begin
            vec_issued <= '0;
            row_issued <= '0;
            vec_got    <= '0;
            row_got    <= '0;
            out_cnt    <= '0;
        end else begin
            if (req_hsk && vec_left) vec_issued <= vec_issued + dim_t'(1);
            if (req_hsk && !vec_left) row_issued <= row_issued + dim_t'(1);
            if (vec_resp_val) vec_got <= vec_got + dim_t'(1);
            if (rowlen_resp_val) row_got <= row_got + dim_t'(1);
            out_cnt <= out_cnt + OUT_W'(req_hsk) - OUT_W'(resp_any);
        end
    end

    // Stores fill in request order
    always_ff @(posedge clk) begin
        if (vec_resp_val) vec_mem[vec_got[`SPMV_DIM_W-1:0]] <= resp_data[`SPMV_DATA_W-1:0];
        if (rowlen_resp_val) row_mem[row_got[`SPMV_DIM_W-1:0]] <= resp_data[`SPMV_DIM_W:0];
    end

endmodule

//--- hw/spmv_result_buf.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_result_buf
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   phase_init,
    input  logic                   row_wr_val,
    input  logic [`SPMV_DIM_W-1:0] row_wr_idx,
    input  elem_t                  row_wr_data,
    input  logic                   readout_start,
    input  dim_t                   spm_nr,
    output logic                   resp_val,
    input  logic                   resp_rdy,
    output mem_word_t              resp_data,
    output logic                   readout_active,
    output logic                   readout_done
);

    elem_t out_mem [`SPMV_MAX_DIM];  // y
    dim_t  rd_idx;
    logic  resp_hsk, last;

    assign resp_val     = readout_active;
    assign resp_data    = mem_word_t'(out_mem[rd_idx[`SPMV_DIM_W-1:0]]);  // Zero-extended
    assign resp_hsk     = resp_val && resp_rdy;
    assign last         = rd_idx == spm_nr - dim_t'(1);
    assign readout_done = resp_hsk && last;

    always_ff @(posedge clk) begin
        if (row_wr_val) out_mem[row_wr_idx] <= row_wr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || phase_init) begin
            readout_active <= 1'b0;
            rd_idx         <= '0;
        end else if (readout_start) begin
            readout_active <= 1'b1;
            rd_idx         <= '0;
        end else if (resp_hsk) begin
            rd_idx <= rd_idx + dim_t'(1);  // Index moves only on handshake
            if (last) readout_active <= 1'b0;
        end
    end

endmodule

//--- hw/spmv_settings.svh
`ifndef SPMV_SETTINGS_SVH
`define SPMV_SETTINGS_SVH

// Element width, one per memory word
`define SPMV_DATA_W     32
// Memory and core word
`define SPMV_MEM_W      64
// Word address
`define SPMV_PADDR_W    40

// Max rows and vector length
`define SPMV_MAX_DIM    64
`define SPMV_DIM_W      6
`define SPMV_NNZ_W      12

// Memory port tag and in-flight limit
`define SPMV_TRANSID_W  6
`define SPMV_MAX_OUT    4

`endif

//--- hw/spmv_top.sv
`timescale 1ns/1ps
`include "spmv_settings.svh"

module spmv_top
    import spmv_cmd_pkg::*;
    import spmv_mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_val,
    input  logic [5:0]                 cmd_opcode,
    input  mem_word_t                  cmd_config_data,
    output logic                       busy,
    output logic                       resp_val,
    input  logic                       resp_rdy,
    output mem_word_t                  resp_data,
    input  logic                       mem_req_rdy,
    output logic                       mem_req_val,
    output logic [`SPMV_TRANSID_W-1:0] mem_req_transid,
    output paddr_t                     mem_req_addr,
    input  logic                       mem_resp_val,
    input  logic [`SPMV_TRANSID_W-1:0] mem_resp_transid,
    input  mem_word_t                  mem_resp_data
);

    //////////////////////////////
    // Control and pointers
    //////////////////////////////
    logic phase_init, phase_prefetch, phase_compute;
    logic readout_start, readout_active, readout_done, prefetch_done;
    dim_t rows_done, vec_len, spm_nr;
    nnz_t spm_nnz;
    paddr_t val_ptr, col_ptr, rowlen_ptr, vec_ptr;

    //////////////////////////////
    // Memory request sides
    //////////////////////////////
    logic      pf_req_val, pf_req_rdy, ef_req_val, ef_req_rdy;
    paddr_t    pf_req_addr, ef_req_addr;
    mem_kind_e pf_req_kind, ef_req_kind;
    logic      vec_resp_val, rowlen_resp_val, val_resp_val, col_resp_val;
    mem_word_t mem_data;

    // Store reads and row writes
    logic [`SPMV_DIM_W-1:0] vec_rd_idx, row_rd_idx, row_wr_idx;
    elem_t                  vec_rd_data, row_wr_data;
    dim_t                   row_rd_len;
    logic                   row_wr_val;

    spmv_ctrl i_ctrl (.*);

    spmv_prefetch i_prefetch (
        .req_val   (pf_req_val),
        .req_rdy   (pf_req_rdy),
        .req_addr  (pf_req_addr),
        .req_kind  (pf_req_kind),
        .resp_data (mem_data),
        .*
    );

    spmv_elem_fetch i_elem_fetch (
        .req_val   (ef_req_val),
        .req_rdy   (ef_req_rdy),
        .req_addr  (ef_req_addr),
        .req_kind  (ef_req_kind),
        .resp_seen (mem_resp_val),  // All compute-phase responses are elements
        .*
    );

    spmv_mem_port i_mem_port (
        .resp_data (mem_data),
        .*
    );

    spmv_mac i_mac (
        .resp_data (mem_data),
        .*
    );

    spmv_result_buf i_result_buf (.*);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the SpMV testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module spmv_tb -o spmv_sim

./obj_dir/spmv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
